// File: project.f
verilog/cache_pkg.sv
verilog/cache_if.sv
verilog/cache_ctrl.sv
verilog/cache_store.sv
verilog/line_mover.sv
verilog/main_mem.sv
verilog/cache_top.sv
sim/tb_clock.sv
sim/cache_props.sv
sim/cache_tb.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module cache_tb -f project.f -o cache_sim \
   > build.log 2>&1 \
   && ./obj_dir/cache_sim > sim.log 2>&1 \
   || { cat build.log sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -qx "RESULT: PASS" sim.log && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }

// File: sim/cache_tb.sv
`default_nettype none

module cache_tb import cache_pkg::*; ();

   localparam int MEM_LAT  = 2;
   localparam int PERIOD   = 4;
   localparam int N_RAND   = 200;
   localparam int N_REQ    = N_RAND + 16;
   localparam int MISS_CYC = 9 * (MEM_LAT + 1) + 4;   // Write-back, fill, final access
   localparam int TIMEOUT  = (2 * N_REQ * MISS_CYC + 20) * PERIOD;

   logic  clk;
   logic  rst_n;
   logic  wb_cyc;
   logic  wb_stb;
   logic  wb_we;
   addr_t wb_adr;
   word_t wb_dat_w;
   word_t wb_dat_r;
   logic  wb_ack;
   logic  cache_hit;

   tag_t  sh_tag [16];
   logic  sh_valid [16];
   word_t written [addr_t];   // Words changed since reset
   addr_t exp_adr;
   word_t exp_data;
   logic  exp_hit;
   logic  exp_we;
   int    errors;
   int    checks;

   tb_clock #(.PERIOD(PERIOD)) tb_clock_i (.clk(clk));

   cache_top #(.MEM_LAT(MEM_LAT)) cache_top_i (
      .clk(clk), .rst_n(rst_n),
      .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
      .wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
      .wb_dat_r(wb_dat_r), .wb_ack(wb_ack), .cache_hit(cache_hit)
   );

   // Returns {hit, data} predicted for an access to a
   function automatic logic [16:0] ref_access(addr_t a);
      index_t idx;
      word_t  data;
      logic   hit;
      idx  = a[5:2];
      hit  = sh_valid[idx] && (sh_tag[idx] == a[15:6]);
      data = written.exists(a) ? written[a] : (a ^ MEM_INIT_KEY);
      return {hit, data};
   endfunction

   task automatic wb_transfer(input addr_t a, input logic we, input word_t d);
      @(posedge clk);
      {exp_hit, exp_data} = ref_access(a);
      exp_adr  = a;
      exp_we   = we;
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      wb_we    <= we;
      wb_adr   <= a;
      wb_dat_w <= d;
      @(negedge clk);
      while (!wb_ack) @(negedge clk);
      sh_valid[a[5:2]] = 1'b1;   // Allocated on hit or miss
      sh_tag[a[5:2]]   = a[15:6];
      if (we) written[a] = d;
   endtask

   task automatic release_bus();
      @(posedge clk);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
   endtask

   always @(negedge clk) begin
      if (rst_n && wb_ack) begin
         checks++;
         assert (cache_hit == exp_hit) else begin
            errors++;
            $display("[FAIL] cache_hit at %h: got %h, expected %h", exp_adr, cache_hit, exp_hit);
         end
         if (!exp_we) begin
            assert (wb_dat_r == exp_data) else begin
               errors++;
               $display("[FAIL] wb_dat_r at %h: got %h, expected %h", exp_adr, wb_dat_r, exp_data);
            end
         end
      end
   end

   initial begin
      addr_t a;
      logic  we;
      errors = 0;
      checks = 0;
      void'($urandom(90358));
      rst_n    = 1'b0;
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;
      wb_adr   = '0;
      wb_dat_w = '0;
      for (int i = 0; i < 16; i++) begin
         sh_valid[i] = 1'b0;
         sh_tag[i]   = '0;
      end
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;

      wb_transfer(16'h0104, 1'b0, '0);      // Cold miss
      wb_transfer(16'h0106, 1'b0, '0);      // Same line hits
      wb_transfer(16'h0104, 1'b0, '0);
      wb_transfer(16'h0105, 1'b1, 16'h1234);
      wb_transfer(16'h0105, 1'b0, '0);
      wb_transfer(16'h0104, 1'b0, '0);      // Neighbors untouched
      wb_transfer(16'h0107, 1'b0, '0);
      wb_transfer(16'h0504, 1'b0, '0);      // Evicts the dirty line
      wb_transfer(16'h0105, 1'b0, '0);      // Written value back from memory
      wb_transfer(16'h0a3a, 1'b1, 16'hbeef);   // Write miss allocates
      wb_transfer(16'h0a38, 1'b0, '0);
      wb_transfer(16'h0a39, 1'b0, '0);
      wb_transfer(16'h0a3b, 1'b0, '0);
      wb_transfer(16'h0a3a, 1'b0, '0);

      // Four tags over two lines keep evicting
      for (int i = 0; i < N_RAND; i++) begin
         a  = {tag_t'($urandom_range(3, 0)), index_t'($urandom_range(1, 0)), offset_t'($urandom)};
         we = ($urandom_range(1, 0) == 1);
         wb_transfer(a, we, word_t'($urandom));
      end
      release_bus();
      repeat (3) @(posedge clk);

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

   initial begin
      #(TIMEOUT);
      $display("Timeout: no Wishbone acknowledge within %0d time units", TIMEOUT);
      $display("Checks: %0d, errors: %0d", checks, errors);
      $display("RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// File: sim/cache_props.sv
`default_nettype none

module cache_props import cache_pkg::*; (
   input logic        clk,
   input logic        rst_n,
   input logic        wb_stb,
   input logic        wb_ack,
   input logic        mem_rd,
   input logic        mem_wr,
   input logic        mem_stall,
   input ctrl_state_t state
);

   logic seen_stb;   // Any strobe since reset

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) seen_stb <= 1'b0;
      else if (wb_stb) seen_stb <= 1'b1;
   end

   a_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n) wb_ack |=> !wb_ack)
      else $error("wb_ack high for two cycles in a row");

   a_mem_excl: assert property (@(posedge clk) disable iff (!rst_n) !(mem_rd && mem_wr))
      else $error("mem_rd and mem_wr high together");

   a_ack_after_stb: assert property (@(posedge clk) disable iff (!rst_n) wb_ack |-> seen_stb)
      else $error("wb_ack before any strobe");

   a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
                                  mem_stall |=> $stable(state))
      else $error("controller state moved during memory stall");

endmodule

bind cache_ctrl cache_props cache_props_i (
   .clk(clk), .rst_n(rst_n), .wb_stb(wb_stb), .wb_ack(wb_ack),
   .mem_rd(mem_rd), .mem_wr(mem_wr), .mem_stall(mem_stall), .state(state)
);

`default_nettype wire

// File: sim/tb_clock.sv
`default_nettype none

module tb_clock #(
   parameter int PERIOD = 4
) (
   output logic clk
);

   initial clk = 1'b0;
   always #(PERIOD / 2) clk = ~clk;

endmodule

`default_nettype wire

// File: verilog/cache_top.sv
`default_nettype none

module cache_top import cache_pkg::*; #(
   parameter int unsigned MEM_LAT = 2
) (
   input  logic  clk,
   input  logic  rst_n,
   input  logic  wb_cyc,
   input  logic  wb_stb,
   input  logic  wb_we,
   input  addr_t wb_adr,
   input  word_t wb_dat_w,
   output word_t wb_dat_r,
   output logic  wb_ack,
   output logic  cache_hit
);

   logic    inc;
   logic    clear;
   logic    mem_rd;
   logic    mem_wr;
   offset_t cnt;

   store_if st_if ();
   mem_if   mem_bus ();

   assign wb_dat_r = st_if.rdata;

   cache_ctrl cache_ctrl_i (
      .clk(clk), .rst_n(rst_n),
      .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
      .wb_ack(wb_ack), .cache_hit(cache_hit),
      .st(st_if.ctrl), .mem_stall(mem_bus.stall), .cnt(cnt),
      .inc(inc), .clear(clear), .mem_rd(mem_rd), .mem_wr(mem_wr)
   );

   cache_store cache_store_i (.clk(clk), .rst_n(rst_n), .st(st_if.store));

   line_mover line_mover_i (
      .clk(clk), .rst_n(rst_n),
      .inc(inc), .clear(clear), .mem_rd(mem_rd), .mem_wr(mem_wr), .cnt(cnt),
      .req_adr(wb_adr), .req_we(wb_we), .req_dat(wb_dat_w),
      .st(st_if.mover), .mem(mem_bus.master)
   );

   main_mem #(.MEM_LAT(MEM_LAT)) main_mem_i (.clk(clk), .rst_n(rst_n), .mem(mem_bus.slave));

endmodule

`default_nettype wire

// File: verilog/main_mem.sv
`default_nettype none

module main_mem import cache_pkg::*; #(
   parameter int unsigned MEM_LAT = 2
) (
   input  logic clk,
   input  logic rst_n,
   mem_if.slave mem
);

   localparam int CW = $clog2(MEM_LAT + 2);

   word_t         ram [65536];
   logic [CW-1:0] lat_q;
   logic          busy;

   initial begin
      for (int i = 0; i < 65536; i++) begin
         ram[i] = word_t'(i) ^ MEM_INIT_KEY;
      end
   end

   assign busy      = mem.rd | mem.wr;
   assign mem.stall = busy && (lat_q != CW'(MEM_LAT));
   assign mem.rdata = ram[mem.addr];

   // Wait cycles of the held request
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) lat_q <= '0;
      else if (busy && mem.stall) lat_q <= lat_q + CW'(1);
      else lat_q <= '0;   // Access done or idle
   end

   always_ff @(posedge clk) begin
      if (mem.wr && !mem.stall) ram[mem.addr] <= mem.wdata;
   end

endmodule

`default_nettype wire

// File: verilog/line_mover.sv
`default_nettype none

module line_mover import cache_pkg::*; (
   input  logic    clk,
   input  logic    rst_n,
   input  logic    inc,
   input  logic    clear,
   input  logic    mem_rd,
   input  logic    mem_wr,
   output offset_t cnt,
   input  addr_t   req_adr,
   input  logic    req_we,
   input  word_t   req_dat,
   store_if.mover  st,
   mem_if.master   mem
);

   tag_t    req_tag;
   index_t  req_idx;
   offset_t req_off;
   tag_t    line_tag;
   logic    merge;

   assign req_tag = req_adr[15:6];
   assign req_idx = req_adr[5:2];
   assign req_off = req_adr[1:0];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) cnt <= '0;
      else if (clear) cnt <= '0;
      else if (inc) cnt <= cnt + offset_t'(1);
   end

   // Victim line goes out, requested line comes in
   assign line_tag  = mem_wr ? st.victim_tag : req_tag;
   assign mem.rd    = mem_rd;
   assign mem.wr    = mem_wr;
   assign mem.addr  = {line_tag, req_idx, cnt};
   assign mem.wdata = st.rdata;

   // Write data merged in while the requested word is filled
   assign merge = req_we && (cnt == req_off);

   assign st.index  = req_idx;
   assign st.tag    = req_tag;
   assign st.offset = (mem_rd || mem_wr) ? cnt : req_off;
   assign st.wdata  = (mem_rd && !merge) ? mem.rdata : req_dat;

endmodule

`default_nettype wire

// File: verilog/cache_store.sv
`default_nettype none

module cache_store import cache_pkg::*; (
   input  logic  clk,
   input  logic  rst_n,
   store_if.store st
);

   localparam int LINES = 16;
   localparam int WORDS = 64;

   tag_t        tag_arr  [LINES];
   word_t       data_arr [WORDS];
   logic [15:0] valid_q;
   logic [15:0] dirty_q;
   logic        wr_en;
   logic [5:0]  word_sel;

   assign wr_en    = st.en & st.cache_wr;
   assign word_sel = {st.index, st.offset};

   // Combinational read side
   assign st.rdata      = data_arr[word_sel];
   assign st.valid      = valid_q[st.index];
   assign st.dirty      = dirty_q[st.index];
   assign st.victim_tag = tag_arr[st.index];
   assign st.hit        = valid_q[st.index] && (tag_arr[st.index] == st.tag);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_q <= '0;
         dirty_q <= '0;
      end else if (wr_en) begin
         if (st.fill) begin
            valid_q[st.index] <= 1'b1;
            dirty_q[st.index] <= 1'b0;   // Fresh copy of memory
         end else if (st.comp) begin
            dirty_q[st.index] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en) begin
         data_arr[word_sel] <= st.wdata;
         if (st.fill) tag_arr[st.index] <= st.tag;
      end
   end

endmodule

`default_nettype wire

// File: verilog/cache_ctrl.sv
`default_nettype none

module cache_ctrl import cache_pkg::*; (
   input  logic    clk,
   input  logic    rst_n,
   input  logic    wb_cyc,
   input  logic    wb_stb,
   input  logic    wb_we,
   output logic    wb_ack,
   output logic    cache_hit,
   store_if.ctrl   st,
   input  logic    mem_stall,
   input  offset_t cnt,
   output logic    inc,
   output logic    clear,
   output logic    mem_rd,
   output logic    mem_wr
);

   ctrl_state_t state;
   ctrl_state_t next_state;
   logic        req;
   logic        ack_set;
   logic        hit_set;

   assign req = wb_cyc & wb_stb;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state     <= s_idle;
         wb_ack    <= 1'b0;
         cache_hit <= 1'b0;
      end else begin
         state     <= next_state;
         wb_ack    <= ack_set;
         cache_hit <= hit_set;
      end
   end

   always_comb begin
      st.en       = 1'b0;
      st.comp     = 1'b0;
      st.cache_wr = 1'b0;
      st.fill     = 1'b0;
      inc         = 1'b0;
      clear       = 1'b0;
      mem_rd      = 1'b0;
      mem_wr      = 1'b0;
      ack_set     = 1'b0;
      hit_set     = 1'b0;
      next_state  = state;

      case (state)
         s_idle: begin
            clear = 1'b1;
            // Ack cycle still shows the old request
            if (req && !wb_ack) begin
               st.en   = 1'b1;
               st.comp = 1'b1;
               if (st.hit && st.valid) begin
                  st.cache_wr = wb_we;
                  ack_set     = 1'b1;
                  hit_set     = 1'b1;
               end else begin
                  next_state = s_access_rd;
               end
            end
         end
         s_access_rd: begin
            st.en      = 1'b1;
            next_state = (st.dirty && st.valid) ? s_mem_wr : s_mem_rd_1;
         end
         s_mem_wr: begin
            st.en  = 1'b1;
            mem_wr = 1'b1;
            if (!mem_stall) begin
               inc = 1'b1;
               if (&cnt) next_state = s_mem_rd_1;   // Last victim word
            end
         end
         s_mem_rd_1, s_mem_rd_2: begin
            mem_rd = 1'b1;
            if (!mem_stall) begin
               st.en       = 1'b1;
               st.cache_wr = 1'b1;
               st.fill     = 1'b1;
               inc         = 1'b1;
               next_state  = (&cnt) ? s_access_wr_2 : s_mem_rd_2;
            end
         end
         s_access_wr_2: begin
            st.en      = 1'b1;
            st.comp    = 1'b1;
            next_state = s_access_wr;
         end
         s_access_wr: begin
            st.en       = 1'b1;
            st.comp     = 1'b1;
            st.cache_wr = wb_we;   // Marks line dirty on a write
            ack_set     = 1'b1;
            next_state  = s_idle;
         end
         default: next_state = s_idle;
      endcase
   end

endmodule

`default_nettype wire

// File: verilog/cache_if.sv
`default_nettype none

interface store_if import cache_pkg::*; ();
   logic    en;
   logic    comp;
   logic    cache_wr;
   logic    fill;
   index_t  index;
   tag_t    tag;
   offset_t offset;
   word_t   wdata;
   word_t   rdata;
   logic    hit;
   logic    dirty;
   logic    valid;
   tag_t    victim_tag;

   modport ctrl  (output en, comp, cache_wr, fill, input hit, dirty, valid);
   modport store (input en, comp, cache_wr, fill, index, tag, offset, wdata,
                  output rdata, hit, dirty, valid, victim_tag);
   modport mover (output index, tag, offset, wdata, input rdata, victim_tag);
endinterface

interface mem_if import cache_pkg::*; ();
   logic  rd;
   logic  wr;
   addr_t addr;
   word_t wdata;
   word_t rdata;
   logic  stall;

   modport master (output rd, wr, addr, wdata, input rdata, stall);
   modport slave  (input rd, wr, addr, wdata, output rdata, stall);
endinterface

`default_nettype wire

// File: verilog/cache_pkg.sv
`default_nettype none

package cache_pkg;

   typedef logic [15:0] word_t;
   typedef logic [15:0] addr_t;
   typedef logic [9:0]  tag_t;
   typedef logic [3:0]  index_t;
   typedef logic [1:0]  offset_t;   // Also the word counter

   // Sparse 4-bit state encodings
   typedef enum logic [3:0] {
      s_idle        = 4'b0000,
      s_access_rd   = 4'b0011,
      s_mem_wr      = 4'b0100,
      s_mem_rd_1    = 4'b0101,
      s_access_wr   = 4'b0110,
      s_access_wr_2 = 4'b0111,
      s_mem_rd_2    = 4'b1000
   } ctrl_state_t;

   // Memory word at address a starts as a ^ key
   localparam word_t MEM_INIT_KEY = 16'hA5C3;

endpackage

`default_nettype wire
